//--- files.f
+incdir+hw
hw/user_io_pkg.sv
hw/spi_byte_rx.sv
hw/io_cmd_decoder.sv
hw/ps2_clk_gen.sv
hw/ps2_tx_channel.sv
hw/user_io_top.sv
verif/tb_clk_gen.sv
verif/user_io_tb.sv

//--- hw/io_cmd_decoder.sv
// held outputs power up at zero and keep their value across transfers; no read commands
`timescale 1ns/10ps
`include "user_io_defines.svh"

module io_cmd_decoder (
	input  logic                               clk_sys,
	input  user_io_pkg::byte_t                 rx_byte_i,
	input  logic                               rx_valid_i,
	input  logic                               xfer_end_i,
	input  logic [`USER_IO_PS2_CHANNELS-1:0]   fifo_ready_i,
	output logic [`USER_IO_PS2_CHANNELS-1:0]   tx_strobe_o,
	output user_io_pkg::byte_t                 tx_byte_o,
	output logic [1:0]                         buttons_o,
	output logic [1:0]                         switches_o,
	output logic                               scandoubler_disable_o,
	output logic                               ypbpr_o,
	output logic                               no_csync_o,
	output logic [`USER_IO_JOY_W-1:0]          joystick_0_o,
	output logic [`USER_IO_JOY_W-1:0]          joystick_1_o,
	output logic [`USER_IO_STATUS_W-1:0]       status_o
);

	localparam int KBD_CH       = 0;
	localparam int MOUSE_CH     = 1;
	localparam int JOY_BYTES    = `USER_IO_JOY_W / `USER_IO_BYTE_W;
	localparam int STATUS_BYTES = `USER_IO_STATUS_W / `USER_IO_BYTE_W;
	localparam int MOUSE_BYTES  = 3;
	localparam int SLOT_W       = $clog2(STATUS_BYTES);
	localparam int JOY_SLOT_W   = $clog2(JOY_BYTES);

	logic [`USER_IO_CNT_W-1:0]               byte_cnt = '0;
	user_io_pkg::io_cmd_e                    cmd = user_io_pkg::CMD_BUT_SW;
	logic                                    pkt_ok = 1'b0;
	logic [`USER_IO_PS2_CHANNELS-1:0]        tx_strobe_q = '0;
	user_io_pkg::byte_t                      tx_byte_q;
	logic [SLOT_W-1:0]                       byte_slot;

	// held registers
	logic [6:0]                   but_sw_q = '0;
	logic [`USER_IO_JOY_W-1:0]    joy0_q = '0;
	logic [`USER_IO_JOY_W-1:0]    joy1_q = '0;
	logic [`USER_IO_STATUS_W-1:0] status_q = '0;

	// payload byte k lands in slot k-1
	assign byte_slot = SLOT_W'(byte_cnt - 1'b1);

	always_ff @(posedge clk_sys) begin
		tx_strobe_q <= '0;
		if (xfer_end_i) begin
			byte_cnt <= '0;
			pkt_ok   <= 1'b0;
		end else if (rx_valid_i) begin
			if (~&byte_cnt) begin
				byte_cnt <= byte_cnt + 1'b1;
			end
			tx_byte_q <= rx_byte_i;
			if (byte_cnt == '0) begin
				cmd <= user_io_pkg::io_cmd_e'(rx_byte_i);
				// whole packet or nothing, decided once per transfer
				case (rx_byte_i)
					user_io_pkg::CMD_KBD:   pkt_ok <= fifo_ready_i[KBD_CH];
					user_io_pkg::CMD_MOUSE: pkt_ok <= fifo_ready_i[MOUSE_CH];
					default:                pkt_ok <= 1'b0;
				endcase
			end else begin
				case (cmd)
					user_io_pkg::CMD_BUT_SW: begin
						but_sw_q <= rx_byte_i[6:0];
					end
					user_io_pkg::CMD_JOY0: begin
						if (byte_cnt <= `USER_IO_CNT_W'(JOY_BYTES)) begin
							joy0_q[byte_slot[JOY_SLOT_W-1:0]*`USER_IO_BYTE_W +: `USER_IO_BYTE_W]
								<= rx_byte_i;
						end
					end
					user_io_pkg::CMD_JOY1: begin
						if (byte_cnt <= `USER_IO_CNT_W'(JOY_BYTES)) begin
							joy1_q[byte_slot[JOY_SLOT_W-1:0]*`USER_IO_BYTE_W +: `USER_IO_BYTE_W]
								<= rx_byte_i;
						end
					end
					user_io_pkg::CMD_STATUS: begin
						if (byte_cnt <= `USER_IO_CNT_W'(STATUS_BYTES)) begin
							status_q[byte_slot*`USER_IO_BYTE_W +: `USER_IO_BYTE_W] <= rx_byte_i;
						end
					end
					user_io_pkg::CMD_KBD: begin
						tx_strobe_q[KBD_CH] <= pkt_ok;
					end
					user_io_pkg::CMD_MOUSE: begin
						// trailing wheel byte is not part of a standard PS/2 packet
						if (byte_cnt <= `USER_IO_CNT_W'(MOUSE_BYTES)) begin
							tx_strobe_q[MOUSE_CH] <= pkt_ok;
						end
					end
					default: begin
					end
				endcase
			end
		end
	end

	assign tx_strobe_o           = tx_strobe_q;
	assign tx_byte_o             = tx_byte_q;
	assign buttons_o             = but_sw_q[1:0];
	assign switches_o            = but_sw_q[3:2];
	assign scandoubler_disable_o = but_sw_q[4];
	assign ypbpr_o               = but_sw_q[5];
	assign no_csync_o            = but_sw_q[6];
	assign joystick_0_o          = joy0_q;
	assign joystick_1_o          = joy1_q;
	assign status_o              = status_q;

endmodule

//--- hw/ps2_clk_gen.sv
// free-running divider shared by all PS/2 channels; starts high and never stops
`timescale 1ns/10ps
`include "user_io_defines.svh"

module ps2_clk_gen (
	input  logic clk_sys,
	output logic ps2_clk_o,
	output logic ps2_rise_o
);

	localparam int DIV_W = $clog2(`USER_IO_PS2_DIV + 1);

	logic [DIV_W-1:0] div_cnt = '0;
	logic             clk_q = 1'b1;
	logic             rise_q = 1'b0;

	always_ff @(posedge clk_sys) begin
		rise_q <= 1'b0;
		if (div_cnt == DIV_W'(`USER_IO_PS2_DIV)) begin
			div_cnt <= '0;
			clk_q   <= ~clk_q;
			// flag only the low-to-high toggle
			rise_q  <= ~clk_q;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	assign ps2_clk_o  = clk_q;
	assign ps2_rise_o = rise_q;

endmodule

//--- hw/ps2_tx_channel.sv
// device-to-host only; one FIFO slot stays unused so full and empty differ
`timescale 1ns/10ps
`include "user_io_defines.svh"

module ps2_tx_channel (
	input  logic               clk_sys,
	input  logic               ps2_clk_i,
	input  logic               ps2_rise_i,
	input  logic               tx_strobe_i,
	input  user_io_pkg::byte_t tx_byte_i,
	output logic               fifo_ready_o,
	output logic               ps2_clk_o,
	output logic               ps2_data_o
);

	localparam int FB    = `USER_IO_PS2_FIFO_BITS;
	localparam int DEPTH = 1 << FB;
	localparam int BIT_W = $clog2(`USER_IO_BYTE_W);

	user_io_pkg::byte_t      fifo_mem [DEPTH];
	logic [FB-1:0]           wptr = '0;
	logic [FB-1:0]           rptr = '0;
	logic [FB-1:0]           fill;

	user_io_pkg::ps2_state_e state = user_io_pkg::PS2_IDLE;
	user_io_pkg::byte_t      shift_q;
	logic                    parity_q;
	logic [BIT_W-1:0]        bit_cnt = '0;
	logic                    data_q = 1'b1;

	assign fill         = wptr - rptr;
	assign fifo_ready_o = (FB'(DEPTH - 1) - fill) >= FB'(`USER_IO_PS2_MIN_FREE);

	always_ff @(posedge clk_sys) begin
		if (tx_strobe_i) begin
			fifo_mem[wptr] <= tx_byte_i;
			wptr           <= wptr + 1'b1;
		end
	end

	// bits change on the rising edge, the host samples on the falling edge
	always_ff @(posedge clk_sys) begin
		if (ps2_rise_i) begin
			case (state)
				user_io_pkg::PS2_IDLE: begin
					data_q <= 1'b1;
					if (wptr != rptr) begin
						shift_q  <= fifo_mem[rptr];
						// odd parity over the data bits
						parity_q <= ~^fifo_mem[rptr];
						rptr     <= rptr + 1'b1;
						bit_cnt  <= '0;
						data_q   <= 1'b0;
						state    <= user_io_pkg::PS2_DATA;
					end
				end
				user_io_pkg::PS2_DATA: begin
					data_q  <= shift_q[0];
					shift_q <= shift_q >> 1;
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == BIT_W'(`USER_IO_BYTE_W - 1)) begin
						state <= user_io_pkg::PS2_PARITY;
					end
				end
				user_io_pkg::PS2_PARITY: begin
					data_q  <= parity_q;
					bit_cnt <= '0;
					state   <= user_io_pkg::PS2_STOP;
				end
				user_io_pkg::PS2_STOP: begin
					// stop bit, then one more rise so its falling edge is seen
					data_q  <= 1'b1;
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt != '0) begin
						state <= user_io_pkg::PS2_IDLE;
					end
				end
				default: begin
					state <= user_io_pkg::PS2_IDLE;
				end
			endcase
		end
	end

	// clock only runs while a frame is on the wire
	assign ps2_clk_o  = ps2_clk_i | (state == user_io_pkg::PS2_IDLE);
	assign ps2_data_o = data_q;

endmodule

//--- hw/spi_byte_rx.sv
// SPI mode 0 slave, MSB first; master must allow at least 8 clk_sys cycles per SPI bit
`timescale 1ns/10ps
`include "user_io_defines.svh"

module spi_byte_rx (
	input  logic                clk_sys,
	input  logic                SPI_SS_IO,
	input  logic                spi_clk_i,
	input  logic                spi_mosi_i,
	output user_io_pkg::byte_t  rx_byte_o,
	output logic                rx_valid_o,
	output logic                xfer_end_o
);

	localparam int BIT_W = $clog2(`USER_IO_BYTE_W);

	// SPI clock domain
	logic [BIT_W-1:0]            bit_cnt;
	logic [`USER_IO_BYTE_W-2:0]  sbuf;
	user_io_pkg::byte_t          byte_q;
	logic                        byte_tog;
	logic                        end_q;

	// clk_sys domain
	logic tog_s1 = 1'b0;
	logic tog_s2 = 1'b0;
	logic tog_d = 1'b0;
	logic end_s1 = 1'b1;
	logic end_s2 = 1'b1;
	logic rx_valid_q = 1'b0;

	// slave select high holds everything in this domain cleared
	always_ff @(posedge spi_clk_i or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			bit_cnt  <= '0;
			sbuf     <= '0;
			byte_q   <= '0;
			byte_tog <= 1'b0;
			end_q    <= 1'b1;
		end else begin
			end_q   <= 1'b0;
			bit_cnt <= bit_cnt + 1'b1;
			if (bit_cnt == BIT_W'(`USER_IO_BYTE_W - 1)) begin
				// last bit completes the byte, flip the toggle for clk_sys
				byte_q   <= {sbuf, spi_mosi_i};
				byte_tog <= ~byte_tog;
			end else begin
				sbuf <= {sbuf[`USER_IO_BYTE_W-3:0], spi_mosi_i};
			end
		end
	end

	// two-flop synchronizers, then edge detect on the toggle
	always_ff @(posedge clk_sys) begin
		tog_s1 <= byte_tog;
		tog_s2 <= tog_s1;
		tog_d  <= tog_s2;
		end_s1 <= end_q;
		end_s2 <= end_s1;
		// toggle clearing at slave select rise is not a byte
		rx_valid_q <= (tog_s2 ^ tog_d) & ~end_s2;
	end

	// byte is stable long before the synchronized pulse arrives
	assign rx_byte_o  = byte_q;
	assign rx_valid_o = rx_valid_q;
	assign xfer_end_o = end_s2;

endmodule

//--- hw/user_io_defines.svh
// link widths and PS/2 timing; DIV assumes clk_sys near 20 MHz for a PS/2 clock near 100 kHz
`ifndef USER_IO_DEFINES_SVH
`define USER_IO_DEFINES_SVH

// one byte on the SPI link
`define USER_IO_BYTE_W 8

// held register widths
`define USER_IO_STATUS_W 64
`define USER_IO_JOY_W 32

// saturating byte counter within one transfer
`define USER_IO_CNT_W 4

// channel 0 is the keyboard, channel 1 the mouse
`define USER_IO_PS2_CHANNELS 2

// PS/2 clock toggles every DIV+1 clk_sys cycles
`define USER_IO_PS2_DIV 100

// log2 of the per-channel FIFO depth
`define USER_IO_PS2_FIFO_BITS 4

// free entries needed before a whole packet is accepted
`define USER_IO_PS2_MIN_FREE 4

`endif

//--- hw/user_io_pkg.sv
// command codes follow the IO controller firmware; unknown codes are carried but never decoded
`include "user_io_defines.svh"

package user_io_pkg;

	// one byte as received from the IO controller
	typedef logic [`USER_IO_BYTE_W-1:0] byte_t;

	// first byte of a transfer selects the command
	typedef enum logic [`USER_IO_BYTE_W-1:0] {
		CMD_BUT_SW = 8'h01,
		CMD_KBD    = 8'h05,
		CMD_STATUS = 8'h1e,
		CMD_JOY0   = 8'h60,
		CMD_JOY1   = 8'h61,
		CMD_MOUSE  = 8'h70
	} io_cmd_e;

	// PS/2 device-to-host frame
	// start bit is driven on the way out of idle
	typedef enum logic [1:0] {
		PS2_IDLE,
		PS2_DATA,
		PS2_PARITY,
		PS2_STOP
	} ps2_state_e;

endpackage

//--- hw/user_io_top.sv
// receive-only IO link: no MISO, no SD, channel 0 keyboard and channel 1 mouse
`timescale 1ns/10ps
`include "user_io_defines.svh"

module user_io_top (
	input  logic                              clk_sys,
	input  logic                              SPI_SS_IO,
	input  logic                              spi_clk_i,
	input  logic                              spi_mosi_i,
	output logic [1:0]                        buttons_o,
	output logic [1:0]                        switches_o,
	output logic                              scandoubler_disable_o,
	output logic                              ypbpr_o,
	output logic                              no_csync_o,
	output logic [`USER_IO_JOY_W-1:0]         joystick_0_o,
	output logic [`USER_IO_JOY_W-1:0]         joystick_1_o,
	output logic [`USER_IO_STATUS_W-1:0]      status_o,
	output logic [`USER_IO_PS2_CHANNELS-1:0]  ps2_clk_o,
	output logic [`USER_IO_PS2_CHANNELS-1:0]  ps2_data_o
);

	logic [`USER_IO_BYTE_W-1:0]       rx_byte;
	logic                             rx_valid;
	logic                             xfer_end;
	logic [`USER_IO_BYTE_W-1:0]       tx_byte;
	logic [`USER_IO_PS2_CHANNELS-1:0] tx_strobe;
	logic [`USER_IO_PS2_CHANNELS-1:0] fifo_ready;
	logic                             ps2_clk;
	logic                             ps2_rise;

	spi_byte_rx i_spi_byte_rx (
		.clk_sys    (clk_sys),
		.SPI_SS_IO  (SPI_SS_IO),
		.spi_clk_i  (spi_clk_i),
		.spi_mosi_i (spi_mosi_i),
		.rx_byte_o  (rx_byte),
		.rx_valid_o (rx_valid),
		.xfer_end_o (xfer_end)
	);

	io_cmd_decoder i_io_cmd_decoder (
		.clk_sys               (clk_sys),
		.rx_byte_i             (rx_byte),
		.rx_valid_i            (rx_valid),
		.xfer_end_i            (xfer_end),
		.fifo_ready_i          (fifo_ready),
		.tx_strobe_o           (tx_strobe),
		.tx_byte_o             (tx_byte),
		.buttons_o             (buttons_o),
		.switches_o            (switches_o),
		.scandoubler_disable_o (scandoubler_disable_o),
		.ypbpr_o               (ypbpr_o),
		.no_csync_o            (no_csync_o),
		.joystick_0_o          (joystick_0_o),
		.joystick_1_o          (joystick_1_o),
		.status_o              (status_o)
	);

	ps2_clk_gen i_ps2_clk_gen (
		.clk_sys    (clk_sys),
		.ps2_clk_o  (ps2_clk),
		.ps2_rise_o (ps2_rise)
	);

	// one serializer per emulated device, all on the shared bit clock
	for (genvar ch = 0; ch < `USER_IO_PS2_CHANNELS; ch++) begin : g_ps2
		ps2_tx_channel i_ps2_tx_channel (
			.clk_sys      (clk_sys),
			.ps2_clk_i    (ps2_clk),
			.ps2_rise_i   (ps2_rise),
			.tx_strobe_i  (tx_strobe[ch]),
			.tx_byte_i    (tx_byte),
			.fifo_ready_o (fifo_ready[ch]),
			.ps2_clk_o    (ps2_clk_o[ch]),
			.ps2_data_o   (ps2_data_o[ch])
		);
	end

endmodule

//--- run.sh
#!/bin/sh
# build and run the user_io testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module user_io_tb \
	--Mdir obj_dir -f files.f

out=$(./obj_dir/Vuser_io_tb) || true
printf '%s\n' "$out"

# pass only when the testbench printed its pass line
printf '%s\n' "$out" | grep -qx 'TEST PASS'

//--- verif/tb_clk_gen.sv
// free-running 20 ns clock; reset output is high for the first 5 rising edges only
`timescale 1ns/10ps

module tb_clk_gen (
	output logic clk_sys_o,
	output logic ss_rst_o
);

	initial begin
		clk_sys_o = 1'b0;
		forever #10 clk_sys_o = ~clk_sys_o;
	end

	// slave select doubles as the link reset
	initial begin
		ss_rst_o = 1'b1;
		repeat (5) @(posedge clk_sys_o);
		ss_rst_o <= 1'b0;
	end

endmodule

//--- verif/user_io_tb.sv
// SPI master runs 8 clk_sys cycles per bit; the table must never fill a PS/2 FIFO
`timescale 1ns/10ps
`include "user_io_defines.svh"

module user_io_tb;

	localparam int N_TESTS      = 8;
	localparam int MAX_BYTES    = 10;
	localparam int FRAME_CYCLES = 12 * 2 * (`USER_IO_PS2_DIV + 1);
	localparam longint WATCHDOG_NS = 2 * 20 * (N_TESTS * 11 * 16 * 4 + 40 * FRAME_CYCLES);

	// command codes of the IO controller
	localparam logic [7:0] C_BUT_SW = 8'h01;
	localparam logic [7:0] C_KBD    = 8'h05;
	localparam logic [7:0] C_STATUS = 8'h1e;
	localparam logic [7:0] C_JOY0   = 8'h60;
	localparam logic [7:0] C_JOY1   = 8'h61;
	localparam logic [7:0] C_MOUSE  = 8'h70;

	logic        clk_sys;
	logic        rst;
	logic        ss = 1'b1;
	logic        spi_clk = 1'b0;
	logic        spi_mosi = 1'b0;
	logic        SPI_SS_IO;
	logic [1:0]  buttons;
	logic [1:0]  switches;
	logic        scandoubler_disable;
	logic        ypbpr;
	logic        no_csync;
	logic [31:0] joystick_0;
	logic [31:0] joystick_1;
	logic [63:0] status;
	logic [1:0]  ps2_clk;
	logic [1:0]  ps2_data;
	logic [6:0]  but_sw_act;

	// transfer table with expected held values after each entry
	string       tname [N_TESTS];
	logic [7:0]  cmds [N_TESTS];
	logic [7:0]  data [N_TESTS][MAX_BYTES];
	int          nbytes [N_TESTS];
	logic [6:0]  exp_but_sw [N_TESTS];
	logic [31:0] exp_joy0 [N_TESTS];
	logic [31:0] exp_joy1 [N_TESTS];
	logic [63:0] exp_status [N_TESTS];

	// reference model state, zero at power up
	logic [6:0]  m_but_sw = '0;
	logic [31:0] m_joy0 = '0;
	logic [31:0] m_joy1 = '0;
	logic [63:0] m_status = '0;
	logic [7:0]  exp_kbd [$];
	logic [7:0]  exp_mouse [$];
	logic [7:0]  rx_kbd [$];
	logic [7:0]  rx_mouse [$];
	int          mon_cnt [2] = '{0, 0};
	logic [10:0] mon_frame [2];
	integer      seed = 32'hc428;

	tb_clk_gen i_tb_clk_gen (
		.clk_sys_o (clk_sys),
		.ss_rst_o  (rst)
	);

	assign SPI_SS_IO  = rst | ss;
	assign but_sw_act = {no_csync, ypbpr, scandoubler_disable, switches, buttons};

	user_io_top i_user_io_top (
		.clk_sys               (clk_sys),
		.SPI_SS_IO             (SPI_SS_IO),
		.spi_clk_i             (spi_clk),
		.spi_mosi_i            (spi_mosi),
		.buttons_o             (buttons),
		.switches_o            (switches),
		.scandoubler_disable_o (scandoubler_disable),
		.ypbpr_o               (ypbpr),
		.no_csync_o            (no_csync),
		.joystick_0_o          (joystick_0),
		.joystick_1_o          (joystick_1),
		.status_o              (status),
		.ps2_clk_o             (ps2_clk),
		.ps2_data_o            (ps2_data)
	);

	task automatic stop_with_failure();
		$display("TEST FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string test, input string what,
			input logic [63:0] exp, input logic [63:0] act);
		assert (act === exp) else begin
			$display("[ERROR] %s %s expected %h actual %h", test, what, exp, act);
			stop_with_failure();
		end
	endtask

	task automatic check_held(input string test, input logic [6:0] bs,
			input logic [31:0] j0, input logic [31:0] j1, input logic [63:0] st);
		check_value(test, "buttons and switches", 64'(bs), 64'(but_sw_act));
		check_value(test, "joystick_0", 64'(j0), 64'(joystick_0));
		check_value(test, "joystick_1", 64'(j1), 64'(joystick_1));
		check_value(test, "status", st, status);
	endtask

	task automatic set_entry(input int e, input string name, input logic [7:0] cmd,
			input int n);
		int k;
		tname[e]  = name;
		cmds[e]   = cmd;
		nbytes[e] = n;
		for (k = 0; k < MAX_BYTES; k++) begin
			data[e][k] = (k < n) ? 8'($random(seed)) : 8'h00;
		end
	endtask

	// command rules applied to one entry, held values carry over
	task automatic apply_model(input int e);
		int k;
		for (k = 0; k < nbytes[e]; k++) begin
			case (cmds[e])
				C_BUT_SW: m_but_sw = data[e][k][6:0];
				C_JOY0:   if (k < 4) m_joy0[8*k +: 8] = data[e][k];
				C_JOY1:   if (k < 4) m_joy1[8*k +: 8] = data[e][k];
				C_STATUS: if (k < 8) m_status[8*k +: 8] = data[e][k];
				C_KBD:    exp_kbd.push_back(data[e][k]);
				C_MOUSE:  if (k < 3) exp_mouse.push_back(data[e][k]);
				default:  ;
			endcase
		end
		exp_but_sw[e] = m_but_sw;
		exp_joy0[e]   = m_joy0;
		exp_joy1[e]   = m_joy1;
		exp_status[e] = m_status;
	endtask

	task automatic build_table();
		int e;
		set_entry(0, "but_sw", C_BUT_SW, 1);
		set_entry(1, "joy0", C_JOY0, 4);
		set_entry(2, "joy1_fifth_byte", C_JOY1, 5);
		set_entry(3, "unknown_cmd", 8'h3c, 4);
		set_entry(4, "status", C_STATUS, 8);
		set_entry(5, "kbd", C_KBD, 6);
		set_entry(6, "mouse_four_bytes", C_MOUSE, 4);
		set_entry(7, "status_short", C_STATUS, 3);
		for (e = 0; e < N_TESTS; e++) begin
			apply_model(e);
		end
	endtask

	// MSB first, MOSI set while the SPI clock is low
	task automatic send_byte(input logic [7:0] b);
		int i;
		for (i = 7; i >= 0; i--) begin
			spi_clk  <= 1'b0;
			spi_mosi <= b[i];
			repeat (4) @(posedge clk_sys);
			spi_clk <= 1'b1;
			repeat (4) @(posedge clk_sys);
		end
	endtask

	task automatic send_transfer(input int e);
		int k;
		ss <= 1'b0;
		repeat (4) @(posedge clk_sys);
		send_byte(cmds[e]);
		for (k = 0; k < nbytes[e]; k++) begin
			send_byte(data[e][k]);
		end
		spi_clk <= 1'b0;
		repeat (4) @(posedge clk_sys);
		ss <= 1'b1;
		repeat (4) @(posedge clk_sys);
	endtask

	// frame is start, 8 data bits, parity, stop
	task automatic take_ps2_bit(input int ch, input logic b);
		// the clock only falls inside a frame, so the first fall carries the start bit
		if (mon_cnt[ch] == 0) begin
			assert (b == 1'b0) else begin
				$display("PS/2 channel %0d clocked while idle or sent a high start bit", ch);
				stop_with_failure();
			end
		end
		mon_frame[ch][mon_cnt[ch]] = b;
		mon_cnt[ch]++;
		if (mon_cnt[ch] == 11) begin
			mon_cnt[ch] = 0;
			assert (^mon_frame[ch][9:1]) else begin
				$display("PS/2 channel %0d sent a frame with bad parity", ch);
				stop_with_failure();
			end
			assert (mon_frame[ch][10]) else begin
				$display("PS/2 channel %0d sent a frame without a stop bit", ch);
				stop_with_failure();
			end
			if (ch == 0) begin
				rx_kbd.push_back(mon_frame[ch][8:1]);
			end else begin
				rx_mouse.push_back(mon_frame[ch][8:1]);
			end
		end
	endtask

	always @(negedge ps2_clk[0])
		take_ps2_bit(0, ps2_data[0]);

	always @(negedge ps2_clk[1])
		take_ps2_bit(1, ps2_data[1]);

	initial begin
		#(WATCHDOG_NS);
		$display("timeout, the run did not finish within %0d ns", WATCHDOG_NS);
		stop_with_failure();
	end

	initial begin
		int e;
		int i;
		build_table();
		@(negedge rst);
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		check_held("reset", 7'h0, 32'h0, 32'h0, 64'h0);
		check_value("reset", "ps2 lines", 64'hf, 64'({ps2_clk, ps2_data}));
		@(posedge clk_sys);
		for (e = 0; e < N_TESTS; e++) begin
			send_transfer(e);
			repeat (20) @(posedge clk_sys);
			@(negedge clk_sys);
			check_held(tname[e], exp_but_sw[e], exp_joy0[e], exp_joy1[e], exp_status[e]);
			@(posedge clk_sys);
		end
		while (rx_kbd.size() < exp_kbd.size() || rx_mouse.size() < exp_mouse.size()) begin
			@(posedge clk_sys);
		end
		// room for a stray frame to show up
		repeat (2 * FRAME_CYCLES) @(posedge clk_sys);
		@(negedge clk_sys);
		check_value("kbd", "frame count", 64'(exp_kbd.size()), 64'(rx_kbd.size()));
		check_value("mouse", "frame count", 64'(exp_mouse.size()), 64'(rx_mouse.size()));
		for (i = 0; i < exp_kbd.size(); i++) begin
			check_value("kbd", $sformatf("byte %0d", i), 64'(exp_kbd[i]), 64'(rx_kbd[i]));
		end
		for (i = 0; i < exp_mouse.size(); i++) begin
			check_value("mouse", $sformatf("byte %0d", i), 64'(exp_mouse[i]),
				64'(rx_mouse[i]));
		end
		check_value("idle", "ps2 lines", 64'hf, 64'({ps2_clk, ps2_data}));
		$display("TEST PASS");
		$finish;
	end

endmodule
